// ==== include/l1_bus_macros.svh ====
// l1 bus adapter constants for widths, line size, buffer depth and burst length
`ifndef L1_BUS_MACROS_SVH
`define L1_BUS_MACROS_SVH

// physical address and bus word
`define L1B_ADDR_W 32
`define L1B_WORD_W 32

// cache line geometry
`define L1B_LINE_W 128
`define L1B_BEATS 4

// transaction id carried with each request
`define L1B_TID_W 2

// entries per cache request buffer
`define L1B_FIFO_DEPTH 2

`endif

// ==== design/l1_bus_pkg.sv ====
// l1 bus adapter types shared by the request path, sequencer and return path
`default_nettype none

`include "l1_bus_macros.svh"

package l1_bus_pkg;

  typedef logic [`L1B_ADDR_W-1:0] paddr_t;
  typedef logic [`L1B_WORD_W-1:0] word_t;
  typedef word_t [`L1B_LINE_W/`L1B_WORD_W-1:0] line_t;
  typedef logic [`L1B_WORD_W/8-1:0] sel_t;
  typedef logic [`L1B_TID_W-1:0] tid_t;
  typedef logic [$clog2(`L1B_BEATS)-1:0] beat_t;

  typedef enum logic {DC_LOAD, DC_STORE} dc_op_e;
  typedef enum logic {DC_LOAD_ACK, DC_STORE_ACK} dc_ack_e;
  typedef enum logic [1:0] {IDLE, BUS, DONE} seq_state_e;

  typedef struct packed {
    paddr_t paddr;
    tid_t   tid;
    logic   nc;
  } ic_req_t;

  // size is 0 for byte, 1 for half, 2 for word
  typedef struct packed {
    dc_op_e     op;
    paddr_t     paddr;
    logic [1:0] size;
    word_t      data;
    tid_t       tid;
  } dc_req_t;

  // port is 0 for the instruction cache, 1 for the data cache
  typedef struct packed {
    logic   port;
    logic   we;
    paddr_t adr;
    word_t  dat;
    sel_t   sel;
    logic   burst;
    tid_t   tid;
  } bus_cmd_t;

  typedef struct packed {
    tid_t  tid;
    line_t line;
  } ic_rtrn_t;

  typedef struct packed {
    dc_ack_e rtype;
    tid_t    tid;
    word_t   data;
  } dc_rtrn_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic   cyc;
    logic   stb;
    logic   we;
    paddr_t adr;
    word_t  dat;
    sel_t   sel;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== design/req_fifo.sv ====
// request buffer holding cache requests until the arbiter takes them
`timescale 1ns/1ps
`default_nettype none

`include "l1_bus_macros.svh"

module req_fifo #(
  parameter int unsigned WIDTH = 35
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  localparam int unsigned DEPTH = `L1B_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== design/req_arbiter.sv ====
// round-robin arbiter between the two cache buffers, building the bus command
`timescale 1ns/1ps
`default_nettype none

`include "l1_bus_macros.svh"

module req_arbiter (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire l1_bus_pkg::ic_req_t  ic_head_i,
  input  wire logic                 ic_valid_i,
  input  wire l1_bus_pkg::dc_req_t  dc_head_i,
  input  wire logic                 dc_valid_i,
  output logic                      ic_pop_o,
  output logic                      dc_pop_o,
  output logic                      cmd_valid_o,
  output l1_bus_pkg::bus_cmd_t      cmd_o,
  input  wire logic                 cmd_ready_i
);

  localparam l1_bus_pkg::paddr_t WORD_MASK = ~l1_bus_pkg::paddr_t'(`L1B_WORD_W/8 - 1);
  localparam l1_bus_pkg::paddr_t LINE_MASK = ~l1_bus_pkg::paddr_t'(`L1B_LINE_W/8 - 1);

  // set when the data port won the last grant
  logic last_dc_q;
  logic pick_dc;
  logic take;

  assign pick_dc     = dc_valid_i & (~ic_valid_i | ~last_dc_q);
  assign cmd_valid_o = ic_valid_i | dc_valid_i;
  assign take        = cmd_valid_o & cmd_ready_i;
  assign ic_pop_o    = take & ~pick_dc;
  assign dc_pop_o    = take & pick_dc;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      last_dc_q <= 1'b1;
    end else if (take) begin
      last_dc_q <= pick_dc;
    end
  end

  ////////////////////
  // command build
  ////////////////////

  always_comb begin : p_cmd
    cmd_o     = '0;
    cmd_o.sel = '1;
    if (pick_dc) begin
      cmd_o.port = 1'b1;
      cmd_o.adr  = dc_head_i.paddr & WORD_MASK;
      cmd_o.tid  = dc_head_i.tid;
      if (dc_head_i.op == l1_bus_pkg::DC_STORE) begin
        cmd_o.we  = 1'b1;
        cmd_o.dat = dc_head_i.data;
        // byte lanes from size and low address bits
        case (dc_head_i.size)
          2'b00:   cmd_o.sel = l1_bus_pkg::sel_t'(1) << dc_head_i.paddr[1:0];
          2'b01:   cmd_o.sel = l1_bus_pkg::sel_t'(3) << {dc_head_i.paddr[1], 1'b0};
          default: cmd_o.sel = '1;
        endcase
      end
    end else begin
      // cacheable refill fetches the whole line
      cmd_o.burst = ~ic_head_i.nc;
      cmd_o.adr   = ic_head_i.nc ? (ic_head_i.paddr & WORD_MASK)
                                 : (ic_head_i.paddr & LINE_MASK);
      cmd_o.tid   = ic_head_i.tid;
    end
  end

  a_one_pop: assert property (@(posedge clk_i) disable iff (!rst_ni) !(ic_pop_o && dc_pop_o));

endmodule

`default_nettype wire

// ==== design/beat_counter.sv ====
// beat counter tracking acknowledged beats of the current bus cycle
`timescale 1ns/1ps
`default_nettype none

`include "l1_bus_macros.svh"

module beat_counter (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         start_i,
  input  wire logic         burst_i,
  input  wire logic         ack_i,
  output l1_bus_pkg::beat_t beat_o,
  output logic              last_o
);

  l1_bus_pkg::beat_t beat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_count
    if (!rst_ni) begin
      beat_q <= '0;
    end else if (start_i) begin
      beat_q <= '0;
    end else if (ack_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign beat_o = beat_q;

  // a single transfer ends on its first beat
  assign last_o = burst_i ? (beat_q == l1_bus_pkg::beat_t'(`L1B_BEATS - 1))
                          : (beat_q == '0);

endmodule

`default_nettype wire

// ==== design/bus_sequencer.sv ====
// wishbone classic master running one bus command at a time
`timescale 1ns/1ps
`default_nettype none

`include "l1_bus_macros.svh"

module bus_sequencer (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  cmd_valid_i,
  input  wire l1_bus_pkg::bus_cmd_t  cmd_i,
  output logic                       cmd_ready_o,
  output l1_bus_pkg::wb_req_t        wb_o,
  input  wire logic                  wb_ack_i,
  input  wire l1_bus_pkg::beat_t     beat_i,
  input  wire logic                  last_i,
  output logic                       start_o,
  output logic                       burst_o,
  output logic                       rd_beat_o,
  output logic                       done_o,
  output logic                       port_o,
  output l1_bus_pkg::tid_t           tid_o
);

  localparam int unsigned BYTE_SHIFT = $clog2(`L1B_WORD_W/8);

  l1_bus_pkg::seq_state_e state_d, state_q;
  l1_bus_pkg::bus_cmd_t   cmd_q;
  logic                   take;
  logic                   beat_ack;

  assign cmd_ready_o = (state_q == l1_bus_pkg::IDLE);
  assign take        = cmd_valid_i & cmd_ready_o;
  assign start_o     = take;

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      l1_bus_pkg::IDLE: if (take) state_d = l1_bus_pkg::BUS;
      l1_bus_pkg::BUS:  if (beat_ack && last_i) state_d = l1_bus_pkg::DONE;
      default:          state_d = l1_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= l1_bus_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_cmd
    if (take) begin
      cmd_q <= cmd_i;
    end
  end

  ////////////////////
  // bus drive
  ////////////////////

  always_comb begin : p_wb
    wb_o.cyc = (state_q == l1_bus_pkg::BUS);
    wb_o.stb = (state_q == l1_bus_pkg::BUS);
    wb_o.we  = cmd_q.we;
    // burst address steps one word per acknowledged beat
    wb_o.adr = cmd_q.adr + (l1_bus_pkg::paddr_t'(beat_i) << BYTE_SHIFT);
    wb_o.dat = cmd_q.dat;
    wb_o.sel = cmd_q.sel;
  end

  assign beat_ack  = wb_o.stb & wb_ack_i;
  assign rd_beat_o = beat_ack & ~cmd_q.we;
  assign done_o    = beat_ack & last_i;
  assign burst_o   = cmd_q.burst;
  assign port_o    = cmd_q.port;
  assign tid_o     = cmd_q.tid;

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni) wb_o.stb |-> wb_o.cyc);
  // stb and the beat address hold through slave wait states
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_o.stb && !wb_ack_i) |=> (wb_o.stb && $stable(wb_o.adr)));
  a_take_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != l1_bus_pkg::IDLE) |-> !(cmd_valid_i && cmd_ready_o));

endmodule

`default_nettype wire

// ==== design/line_assembler.sv ====
// return path collecting read beats and issuing one-cycle return packets
`timescale 1ns/1ps
`default_nettype none

module line_assembler (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                rd_beat_i,
  input  wire l1_bus_pkg::beat_t   beat_i,
  input  wire l1_bus_pkg::word_t   wb_dat_i,
  input  wire logic                done_i,
  input  wire logic                we_i,
  input  wire logic                port_i,
  input  wire l1_bus_pkg::tid_t    tid_i,
  output logic                     ic_rtrn_vld_o,
  output l1_bus_pkg::ic_rtrn_t     ic_rtrn_o,
  output logic                     dc_rtrn_vld_o,
  output l1_bus_pkg::dc_rtrn_t     dc_rtrn_o
);

  l1_bus_pkg::line_t   line_q;
  l1_bus_pkg::tid_t    tid_q;
  l1_bus_pkg::dc_ack_e rtype_q;
  logic                ic_vld_q;
  logic                dc_vld_q;

  // a single word read lands in slot 0
  always_ff @(posedge clk_i) begin : p_payload
    if (rd_beat_i) begin
      line_q[beat_i] <= wb_dat_i;
    end
    if (done_i) begin
      tid_q   <= tid_i;
      rtype_q <= we_i ? l1_bus_pkg::DC_STORE_ACK : l1_bus_pkg::DC_LOAD_ACK;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      ic_vld_q <= 1'b0;
      dc_vld_q <= 1'b0;
    end else begin
      ic_vld_q <= done_i & ~port_i;
      dc_vld_q <= done_i & port_i;
    end
  end

  always_comb begin : p_rtrn
    ic_rtrn_vld_o   = ic_vld_q;
    ic_rtrn_o.tid   = tid_q;
    ic_rtrn_o.line  = line_q;
    dc_rtrn_vld_o   = dc_vld_q;
    dc_rtrn_o.rtype = rtype_q;
    dc_rtrn_o.tid   = tid_q;
    dc_rtrn_o.data  = line_q[0];
  end

  a_one_rtrn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ic_rtrn_vld_o && dc_rtrn_vld_o));

endmodule

`default_nettype wire

// ==== design/l1_bus_adapter.sv ====
// l1 bus adapter joining instruction and data cache requests onto wishbone
`timescale 1ns/1ps
`default_nettype none

module l1_bus_adapter (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 ic_req_i,
  input  wire l1_bus_pkg::ic_req_t  ic_req_data_i,
  output logic                      ic_ack_o,
  input  wire logic                 dc_req_i,
  input  wire l1_bus_pkg::dc_req_t  dc_req_data_i,
  output logic                      dc_ack_o,
  output l1_bus_pkg::wb_req_t       wb_o,
  input  wire logic                 wb_ack_i,
  input  wire l1_bus_pkg::word_t    wb_dat_i,
  output logic                      ic_rtrn_vld_o,
  output l1_bus_pkg::ic_rtrn_t      ic_rtrn_o,
  output logic                      dc_rtrn_vld_o,
  output l1_bus_pkg::dc_rtrn_t      dc_rtrn_o
);

  l1_bus_pkg::ic_req_t  ic_head;
  l1_bus_pkg::dc_req_t  dc_head;
  l1_bus_pkg::bus_cmd_t cmd;
  l1_bus_pkg::beat_t    beat;
  l1_bus_pkg::tid_t     seq_tid;
  logic ic_full, ic_empty, ic_pop;
  logic dc_full, dc_empty, dc_pop;
  logic cmd_valid, cmd_ready;
  logic start, burst, last, rd_beat, done, seq_port;

  // accept whenever the port buffer has room
  assign ic_ack_o = ic_req_i & ~ic_full;
  assign dc_ack_o = dc_req_i & ~dc_full;

  ////////////////////
  // request path
  ////////////////////

  req_fifo #(.WIDTH($bits(l1_bus_pkg::ic_req_t))) u_ic_fifo (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(ic_ack_o), .data_i(ic_req_data_i),
    .pop_i(ic_pop), .data_o(ic_head), .full_o(ic_full), .empty_o(ic_empty)
  );

  req_fifo #(.WIDTH($bits(l1_bus_pkg::dc_req_t))) u_dc_fifo (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(dc_ack_o), .data_i(dc_req_data_i),
    .pop_i(dc_pop), .data_o(dc_head), .full_o(dc_full), .empty_o(dc_empty)
  );

  req_arbiter u_arbiter (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .ic_head_i(ic_head), .ic_valid_i(~ic_empty), .dc_head_i(dc_head), .dc_valid_i(~dc_empty),
    .ic_pop_o(ic_pop), .dc_pop_o(dc_pop),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd), .cmd_ready_i(cmd_ready)
  );

  ////////////////////
  // bus and return
  ////////////////////

  beat_counter u_beats (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start), .burst_i(burst),
    .ack_i(wb_ack_i), .beat_o(beat), .last_o(last)
  );

  bus_sequencer u_sequencer (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cmd_valid_i(cmd_valid), .cmd_i(cmd), .cmd_ready_o(cmd_ready),
    .wb_o(wb_o), .wb_ack_i(wb_ack_i), .beat_i(beat), .last_i(last),
    .start_o(start), .burst_o(burst), .rd_beat_o(rd_beat), .done_o(done),
    .port_o(seq_port), .tid_o(seq_tid)
  );

  line_assembler u_assembler (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .rd_beat_i(rd_beat), .beat_i(beat), .wb_dat_i(wb_dat_i),
    .done_i(done), .we_i(wb_o.we), .port_i(seq_port), .tid_i(seq_tid),
    .ic_rtrn_vld_o(ic_rtrn_vld_o), .ic_rtrn_o(ic_rtrn_o),
    .dc_rtrn_vld_o(dc_rtrn_vld_o), .dc_rtrn_o(dc_rtrn_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_checker.sv ====
// testbench checker comparing l1 bus adapter returns against a shadow memory
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter logic [31:0] MEM_BASE  = 32'h0000_1000,
  parameter int          MEM_WORDS = 64,
  parameter logic [31:0] FILL_XOR  = 32'hA5A5_0000
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 ic_req_i,
  input  wire l1_bus_pkg::ic_req_t  ic_req_data_i,
  input  wire logic                 ic_ack_i,
  input  wire logic                 dc_req_i,
  input  wire l1_bus_pkg::dc_req_t  dc_req_data_i,
  input  wire logic                 dc_ack_i,
  input  wire logic [3:0]           dc_exp_sel_i,
  input  wire l1_bus_pkg::wb_req_t  wb_i,
  input  wire logic                 wb_ack_i,
  input  wire logic                 ic_rtrn_vld_i,
  input  wire l1_bus_pkg::ic_rtrn_t ic_rtrn_i,
  input  wire logic                 dc_rtrn_vld_i,
  input  wire l1_bus_pkg::dc_rtrn_t dc_rtrn_i,
  output int                        err_cnt_o,
  output int                        rtrn_cnt_o,
  output int                        pending_o
);

  localparam int LINE_BEATS = 4;

  logic [31:0]  shadow [MEM_WORDS];
  logic [1:0]   ic_tid_q[$];
  logic [127:0] ic_line_q[$];
  bit           ic_nc_q[$];
  logic [1:0]   dc_tid_q[$];
  bit           dc_st_q[$];
  logic [31:0]  dc_data_q[$];
  logic [3:0]   dc_sel_q[$];
  int           ack_cnt;
  bit           seen_req;

  function automatic bit in_window(input logic [31:0] a);
    return (a >= MEM_BASE) && (a < MEM_BASE + 4 * MEM_WORDS);
  endfunction

  function automatic int word_idx(input logic [31:0] a);
    return int'((a - MEM_BASE) >> 2);
  endfunction

  task automatic report_error(input string sig, input logic [127:0] exp, input logic [127:0] got);
    $display("ERROR at %0d ns: %s expected %h, got %h", $time, sig, exp, got);
    err_cnt_o++;
  endtask

  task automatic report_failure(input string msg);
    $display("%0d ns: %s", $time, msg);
    err_cnt_o++;
  endtask

  initial begin : p_init
    err_cnt_o  = 0;
    rtrn_cnt_o = 0;
    pending_o  = 0;
    ack_cnt    = 0;
    seen_req   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = (MEM_BASE + 4 * i) ^ FILL_XOR;
    end
  end

  always @(posedge clk_i) begin : p_watch
    logic [31:0]  base;
    logic [127:0] line;
    int           errs_before;
    int           beats;
    if (rst_ni) begin
      if (!seen_req && (wb_i.cyc || wb_i.stb || ic_rtrn_vld_i || dc_rtrn_vld_i)) begin
        report_failure("bus cycle or return seen before any request was accepted");
      end
      if (ic_rtrn_vld_i && dc_rtrn_vld_i) begin
        report_failure("instruction and data returns were valid in the same cycle");
      end
      if (wb_i.stb && !wb_i.cyc) begin
        report_failure("stb was high without cyc");
      end
      // cyc holds across every beat and the return follows the last ack
      if (!wb_i.cyc && ack_cnt != 0 && !ic_rtrn_vld_i && !dc_rtrn_vld_i) begin
        report_failure("cyc dropped after an ack with no return in the next cycle");
      end

      ////////////////////
      // bus beats
      ////////////////////
      if (wb_i.stb && wb_ack_i) begin
        ack_cnt++;
        if (wb_i.we && dc_sel_q.size() == 0) begin
          report_failure("store beat on the bus with no data request outstanding");
        end else if (wb_i.we) begin
          if (wb_i.sel != dc_sel_q[0]) report_error("wb_o.sel", dc_sel_q[0], wb_i.sel);
          if (wb_i.dat != dc_data_q[0]) report_error("wb_o.dat", dc_data_q[0], wb_i.dat);
        end
      end

      ////////////////////
      // returns
      ////////////////////
      if (ic_rtrn_vld_i) begin
        if (ic_tid_q.size() == 0) begin
          report_failure("instruction return arrived with no request outstanding");
        end else begin
          errs_before = err_cnt_o;
          beats = ic_nc_q[0] ? 1 : LINE_BEATS;
          if (ic_rtrn_i.tid != ic_tid_q[0]) begin
            report_error("ic_rtrn_o.tid", ic_tid_q[0], ic_rtrn_i.tid);
          end
          // only word 0 is defined for a non-cacheable fetch
          if (ic_nc_q[0] && ic_rtrn_i.line[0] != ic_line_q[0][31:0]) begin
            report_error("ic_rtrn_o.line[0]", ic_line_q[0][31:0], ic_rtrn_i.line[0]);
          end else if (!ic_nc_q[0] && ic_rtrn_i.line != ic_line_q[0]) begin
            report_error("ic_rtrn_o.line", ic_line_q[0], ic_rtrn_i.line);
          end
          if (ack_cnt != beats) report_error("wb_ack_i beats", beats, ack_cnt);
          $display("%0d ns: ic return tid %0d %s", $time, ic_rtrn_i.tid,
                   (err_cnt_o == errs_before) ? "pass" : "fail");
          void'(ic_tid_q.pop_front());
          void'(ic_line_q.pop_front());
          void'(ic_nc_q.pop_front());
          rtrn_cnt_o++;
        end
        ack_cnt = 0;
      end
      if (dc_rtrn_vld_i) begin
        if (dc_tid_q.size() == 0) begin
          report_failure("data return arrived with no request outstanding");
        end else begin
          errs_before = err_cnt_o;
          if (dc_rtrn_i.tid != dc_tid_q[0]) begin
            report_error("dc_rtrn_o.tid", dc_tid_q[0], dc_rtrn_i.tid);
          end
          if (dc_rtrn_i.rtype != (dc_st_q[0] ? l1_bus_pkg::DC_STORE_ACK
                                             : l1_bus_pkg::DC_LOAD_ACK)) begin
            report_error("dc_rtrn_o.rtype", dc_st_q[0], dc_rtrn_i.rtype);
          end
          if (!dc_st_q[0] && dc_rtrn_i.data != dc_data_q[0]) begin
            report_error("dc_rtrn_o.data", dc_data_q[0], dc_rtrn_i.data);
          end
          if (ack_cnt != 1) report_error("wb_ack_i beats", 1, ack_cnt);
          $display("%0d ns: dc %s return tid %0d %s", $time, dc_st_q[0] ? "store" : "load",
                   dc_rtrn_i.tid, (err_cnt_o == errs_before) ? "pass" : "fail");
          void'(dc_tid_q.pop_front());
          void'(dc_st_q.pop_front());
          void'(dc_data_q.pop_front());
          void'(dc_sel_q.pop_front());
          rtrn_cnt_o++;
        end
        ack_cnt = 0;
      end

      ////////////////////
      // accepted requests
      ////////////////////
      if (ic_req_i && ic_ack_i) begin
        seen_req = 1'b1;
        base = ic_req_data_i.nc ? {ic_req_data_i.paddr[31:2], 2'b00}
                                : {ic_req_data_i.paddr[31:4], 4'b0000};
        line = '0;
        if (!in_window(base)) begin
          report_failure("instruction request address lies outside the modeled memory");
        end else begin
          for (int i = 0; i < LINE_BEATS; i++) begin
            if (!ic_req_data_i.nc || i == 0) line[32*i +: 32] = shadow[word_idx(base + 4 * i)];
          end
        end
        ic_tid_q.push_back(ic_req_data_i.tid);
        ic_line_q.push_back(line);
        ic_nc_q.push_back(ic_req_data_i.nc);
      end
      if (dc_req_i && dc_ack_i) begin
        seen_req = 1'b1;
        base = {dc_req_data_i.paddr[31:2], 2'b00};
        if (!in_window(base)) begin
          report_failure("data request address lies outside the modeled memory");
          dc_data_q.push_back('0);
        end else if (dc_req_data_i.op == l1_bus_pkg::DC_STORE) begin
          // merge lane by lane in acceptance order
          for (int b = 0; b < 4; b++) begin
            if (dc_exp_sel_i[b]) shadow[word_idx(base)][8*b +: 8] = dc_req_data_i.data[8*b +: 8];
          end
          dc_data_q.push_back(dc_req_data_i.data);
        end else begin
          dc_data_q.push_back(shadow[word_idx(base)]);
        end
        dc_tid_q.push_back(dc_req_data_i.tid);
        dc_st_q.push_back(dc_req_data_i.op == l1_bus_pkg::DC_STORE);
        dc_sel_q.push_back(dc_exp_sel_i);
      end
      pending_o = ic_tid_q.size() + dc_tid_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_l1_bus_adapter.sv ====
// testbench for the l1 bus adapter with a wishbone memory slave and stimulus table
`timescale 1ns/1ps
`default_nettype none

module tb_l1_bus_adapter;

  localparam int          CLK_PERIOD = 8;
  localparam int          RST_CYCLES = 8;
  localparam int          NUM_ROWS   = 20;
  localparam int          MAX_CYCLES = NUM_ROWS * 24 + 100;
  localparam logic [31:0] MEM_BASE   = 32'h0000_1000;
  localparam int          MEM_WORDS  = 64;
  localparam logic [31:0] FILL_XOR   = 32'hA5A5_0000;

  // op is store for the data port and non-cacheable for the instruction port
  typedef struct packed {
    logic        port;
    logic        op;
    logic [31:0] paddr;
    logic [1:0]  size;
    logic [31:0] data;
    logic [1:0]  tid;
    logic [3:0]  exp_sel;
    logic [3:0]  gap;
  } row_t;

  logic clk, rst_n;
  logic ic_req, ic_ack, dc_req, dc_ack, wb_ack, ic_rtrn_vld, dc_rtrn_vld;
  logic [3:0]            dc_exp_sel;
  l1_bus_pkg::ic_req_t   ic_req_data;
  l1_bus_pkg::dc_req_t   dc_req_data;
  l1_bus_pkg::wb_req_t   wb;
  l1_bus_pkg::word_t     wb_dat;
  l1_bus_pkg::ic_rtrn_t  ic_rtrn;
  l1_bus_pkg::dc_rtrn_t  dc_rtrn;
  row_t                  rows [NUM_ROWS];
  logic [31:0]           mem [MEM_WORDS];
  int                    err_cnt, rtrn_cnt, pending, tb_errs, cycles, row_cnt, wait_left;
  integer                seed;

  l1_bus_adapter u_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .ic_req_i(ic_req), .ic_req_data_i(ic_req_data), .ic_ack_o(ic_ack),
    .dc_req_i(dc_req), .dc_req_data_i(dc_req_data), .dc_ack_o(dc_ack),
    .wb_o(wb), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat),
    .ic_rtrn_vld_o(ic_rtrn_vld), .ic_rtrn_o(ic_rtrn),
    .dc_rtrn_vld_o(dc_rtrn_vld), .dc_rtrn_o(dc_rtrn)
  );

  tb_checker #(.MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS), .FILL_XOR(FILL_XOR)) u_checker (
    .clk_i(clk), .rst_ni(rst_n),
    .ic_req_i(ic_req), .ic_req_data_i(ic_req_data), .ic_ack_i(ic_ack),
    .dc_req_i(dc_req), .dc_req_data_i(dc_req_data), .dc_ack_i(dc_ack),
    .dc_exp_sel_i(dc_exp_sel), .wb_i(wb), .wb_ack_i(wb_ack),
    .ic_rtrn_vld_i(ic_rtrn_vld), .ic_rtrn_i(ic_rtrn),
    .dc_rtrn_vld_i(dc_rtrn_vld), .dc_rtrn_i(dc_rtrn),
    .err_cnt_o(err_cnt), .rtrn_cnt_o(rtrn_cnt), .pending_o(pending)
  );

  initial begin : p_clk
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // memory slave
  ////////////////////

  // random wait states before each ack and stores merged by byte lane
  initial begin : p_slave
    int idx;
    seed   = 42;
    wb_ack = 1'b0;
    wb_dat = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = (MEM_BASE + 4 * i) ^ FILL_XOR;
    wait_left = $random(seed) & 3;
    forever begin
      @(negedge clk);
      if (wb_ack) begin
        wb_ack = 1'b0;
      end else if (wb.stb && wait_left > 0) begin
        wait_left--;
      end else if (wb.stb) begin
        idx = int'((wb.adr - MEM_BASE) >> 2);
        if (wb.adr < MEM_BASE || idx >= MEM_WORDS) begin
          $display("%0d ns: slave access at %h lies outside the modeled memory", $time, wb.adr);
          tb_errs++;
          wb_dat = '0;
        end else if (wb.we) begin
          for (int b = 0; b < 4; b++) if (wb.sel[b]) mem[idx][8*b +: 8] = wb.dat[8*b +: 8];
        end else begin
          wb_dat = mem[idx];
        end
        wb_ack = 1'b1;
        wait_left = $random(seed) & 3;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic add_row(input logic port, input logic op, input logic [31:0] paddr,
                         input logic [1:0] size, input logic [31:0] data, input logic [1:0] tid,
                         input logic [3:0] exp_sel, input logic [3:0] gap);
    rows[row_cnt] = '{port: port, op: op, paddr: paddr, size: size, data: data, tid: tid,
                      exp_sel: exp_sel, gap: gap};
    row_cnt++;
  endtask

  task automatic fill_table();
    row_cnt = 0;
    // directed refills, then stores of each size and loads of the merged words
    add_row(1'b0, 1'b0, 32'h0000_1004, 2'd2, 32'h0, 2'd1, 4'b1111, 4'd2);
    add_row(1'b0, 1'b1, 32'h0000_1038, 2'd2, 32'h0, 2'd2, 4'b1111, 4'd1);
    add_row(1'b1, 1'b1, 32'h0000_1081, 2'd0, 32'h1122_3344, 2'd0, 4'b0010, 4'd2);
    add_row(1'b1, 1'b1, 32'h0000_1086, 2'd1, 32'h5566_7788, 2'd1, 4'b1100, 4'd1);
    add_row(1'b1, 1'b1, 32'h0000_108c, 2'd2, 32'hdead_beef, 2'd2, 4'b1111, 4'd1);
    add_row(1'b1, 1'b0, 32'h0000_1080, 2'd2, 32'h0, 2'd3, 4'b1111, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_1086, 2'd2, 32'h0, 2'd0, 4'b1111, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_108c, 2'd2, 32'h0, 2'd1, 4'b1111, 4'd0);
    // back to back from both ports
    add_row(1'b0, 1'b0, 32'h0000_1010, 2'd2, 32'h0, 2'd3, 4'b1111, 4'd0);
    add_row(1'b0, 1'b0, 32'h0000_1024, 2'd2, 32'h0, 2'd0, 4'b1111, 4'd0);
    add_row(1'b0, 1'b1, 32'h0000_1044, 2'd2, 32'h0, 2'd1, 4'b1111, 4'd0);
    add_row(1'b0, 1'b0, 32'h0000_103c, 2'd2, 32'h0, 2'd2, 4'b1111, 4'd0);
    add_row(1'b0, 1'b0, 32'h0000_1070, 2'd2, 32'h0, 2'd3, 4'b1111, 4'd0);
    add_row(1'b1, 1'b1, 32'h0000_10a0, 2'd2, 32'haabb_ccdd, 2'd2, 4'b1111, 4'd0);
    add_row(1'b1, 1'b1, 32'h0000_10a7, 2'd0, 32'h99aa_bbcc, 2'd3, 4'b1000, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_10a4, 2'd2, 32'h0, 2'd0, 4'b1111, 4'd0);
    add_row(1'b1, 1'b1, 32'h0000_10b2, 2'd1, 32'h1234_5678, 2'd1, 4'b1100, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_10b0, 2'd2, 32'h0, 2'd2, 4'b1111, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_10a0, 2'd2, 32'h0, 2'd3, 4'b1111, 4'd0);
    add_row(1'b1, 1'b0, 32'h0000_10c8, 2'd2, 32'h0, 2'd0, 4'b1111, 4'd0);
  endtask

  // hold the request until the port acknowledges it
  task automatic issue_row(input row_t r);
    repeat (r.gap) @(negedge clk);
    if (r.port) begin
      dc_req_data.op    = r.op ? l1_bus_pkg::DC_STORE : l1_bus_pkg::DC_LOAD;
      dc_req_data.paddr = r.paddr;
      dc_req_data.size  = r.size;
      dc_req_data.data  = r.data;
      dc_req_data.tid   = r.tid;
      dc_exp_sel        = r.exp_sel;
      dc_req            = 1'b1;
      @(posedge clk);
      while (!dc_ack) @(posedge clk);
      @(negedge clk);
      dc_req = 1'b0;
    end else begin
      ic_req_data.paddr = r.paddr;
      ic_req_data.tid   = r.tid;
      ic_req_data.nc    = r.op;
      ic_req            = 1'b1;
      @(posedge clk);
      while (!ic_ack) @(posedge clk);
      @(negedge clk);
      ic_req = 1'b0;
    end
  endtask

  task automatic run_port(input logic port);
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].port == port) issue_row(rows[i]);
    end
  endtask

  initial begin : p_main
    rst_n       = 1'b0;
    ic_req      = 1'b0;
    dc_req      = 1'b0;
    ic_req_data = '0;
    dc_req_data = '0;
    dc_exp_sel  = '0;
    tb_errs     = 0;
    fill_table();
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // idle cycles so the checker sees a quiet bus after reset
    repeat (3) @(negedge clk);
    fork
      run_port(1'b0);
      run_port(1'b1);
    join
    while (pending != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("returns checked: %0d, errors: %0d", rtrn_cnt, err_cnt + tb_errs);
    if (err_cnt + tb_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : p_timeout
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run exceeded %0d cycles with %0d returns outstanding", cycles, pending);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/l1_bus_pkg.sv
design/req_fifo.sv
design/req_arbiter.sv
design/beat_counter.sv
design/bus_sequencer.sv
design/line_assembler.sv
design/l1_bus_adapter.sv
tests/tb_checker.sv
tests/tb_l1_bus_adapter.sv

// ==== Bender.yml ====
package:
  name: l1_bus_adapter

sources:
  - include_dirs:
      - include
    files:
      - design/l1_bus_pkg.sv
      - design/req_fifo.sv
      - design/req_arbiter.sv
      - design/beat_counter.sv
      - design/bus_sequencer.sv
      - design/line_assembler.sv
      - design/l1_bus_adapter.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_l1_bus_adapter.sv
